// ==== pano_soc.f ====
source/soc_pkg.sv
source/mem_bus_decode.sv
source/sram_words.sv
source/gpio_regs.sv
source/text_vram.sv
source/pano_soc.sv
tests/pano_soc_assert.sv
tests/pano_soc_checker.sv
tests/pano_soc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pano_soc testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module pano_soc_tb \
    -f pano_soc.f -o sim_pano_soc \
    && ./obj_dir/sim_pano_soc 2>&1 | tee sim.log \
    && grep -q "all tests passed" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }

// ==== source/gpio_regs.sv ====
`default_nettype none

module gpio_regs (
    input  wire                  clk_rv,
    input  wire                  rst_rv,
    input  wire                  sel,
    input  wire soc_pkg::strb_t  wstrb,
    input  wire soc_pkg::word_t  addr,
    input  wire soc_pkg::word_t  wdata,
    input  wire                  spi_miso,
    input  wire [4:0]            delay_sel_det,
    output soc_pkg::word_t       rdata,
    output soc_pkg::gpio_pins_t  gpio_pins,
    output logic [4:0]           delay_sel_val
);

    // Register map by word index
    //   0  R delay_sel_det  W delay_sel_val
    //   1  W green LED
    //   2  W red LED
    //   3  W SPI chip select
    //   4  W SPI clock
    //   5  W SPI MOSI
    //   6  R SPI MISO
    //   7  W USB reset

    logic [2:0] reg_idx;
    logic       wr_en;
    logic       rd_en;

    assign reg_idx = addr[4:2];
    // Any strobe bit makes it a write
    assign wr_en   = sel && (wstrb != '0);
    assign rd_en   = sel && (wstrb == '0);

    // ------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            // Delay tap starts at the detected value
            delay_sel_val         <= delay_sel_det;
            // LEDs off
            gpio_pins.led_green_n <= 1'b1;
            gpio_pins.led_red_n   <= 1'b1;
            // Flash deselected
            gpio_pins.spi_cs_n    <= 1'b1;
            gpio_pins.spi_clk     <= 1'b0;
            gpio_pins.spi_mosi    <= 1'b0;
            // USB held in reset
            gpio_pins.usb_rst_n   <= 1'b0;
        end else if (wr_en) begin
            case (reg_idx)
                3'd0: delay_sel_val         <= wdata[4:0];
                // LED pins are active low
                3'd1: gpio_pins.led_green_n <= ~wdata[0];
                3'd2: gpio_pins.led_red_n   <= ~wdata[0];
                3'd3: gpio_pins.spi_cs_n    <= wdata[0];
                3'd4: gpio_pins.spi_clk     <= wdata[0];
                3'd5: gpio_pins.spi_mosi    <= wdata[0];
                3'd7: gpio_pins.usb_rst_n   <= wdata[0];
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Read-back
    // ------------------------------------------------------------------

    // Captured during the select cycle for use with ready
    always_ff @(posedge clk_rv) begin
        if (rd_en) begin
            case (reg_idx)
                3'd0:    rdata <= soc_pkg::word_t'(delay_sel_det);
                3'd6:    rdata <= soc_pkg::word_t'(spi_miso);
                default: rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_bus_decode.sv ====
`default_nettype none

module mem_bus_decode #(
    parameter int MEM_WORDS = 1024
) (
    input  wire                      clk_rv,
    input  wire                      rst_rv,
    input  wire soc_pkg::cpu_req_t   cpu_req,
    input  wire soc_pkg::word_t      la_addr,
    input  wire                      ddr_ready,
    input  wire soc_pkg::word_t      ddr_rdata,
    input  wire soc_pkg::word_t      ram_rdata,
    input  wire soc_pkg::word_t      gpio_rdata,
    output logic                     cpu_ready,
    output soc_pkg::word_t           cpu_rdata,
    output soc_pkg::ddr_req_t        ddr_req,
    output soc_pkg::region_t         region,
    output logic [2:0]               target_sel
);

    // First byte address past the internal RAM
    localparam soc_pkg::word_t RAM_LIMIT = soc_pkg::word_t'(MEM_WORDS * 4);

    soc_pkg::region_t la_region;
    logic             default_ready;
    logic             pending;

    // ------------------------------------------------------------------
    // Look-ahead decode
    // ------------------------------------------------------------------

    always_comb begin
        if (la_addr < RAM_LIMIT) begin
            la_region = soc_pkg::REGION_RAM;
        end else if ((la_addr >= soc_pkg::GPIO_BASE) &&
                     (la_addr < soc_pkg::GPIO_BASE + soc_pkg::GPIO_SIZE)) begin
            la_region = soc_pkg::REGION_GPIO;
        end else if ((la_addr >= soc_pkg::VRAM_BASE) &&
                     (la_addr < soc_pkg::VRAM_BASE + soc_pkg::VRAM_SIZE)) begin
            la_region = soc_pkg::REGION_VRAM;
        end else if ((la_addr >= soc_pkg::DDR_BASE) &&
                     (la_addr < soc_pkg::DDR_BASE + soc_pkg::DDR_SIZE)) begin
            la_region = soc_pkg::REGION_DDR;
        end else begin
            la_region = soc_pkg::REGION_NONE;
        end
    end

    // Region follows la_addr on every clock
    // Ready for local targets comes one cycle after valid
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            region        <= soc_pkg::REGION_NONE;
            default_ready <= 1'b0;
        end else begin
            region        <= la_region;
            // Drop again right after the ready cycle
            default_ready <= cpu_req.valid && !cpu_ready;
        end
    end

    // ------------------------------------------------------------------
    // Ready and steering
    // ------------------------------------------------------------------

    // DDR bridge owns ready in its region
    assign cpu_ready = (region == soc_pkg::REGION_DDR) ? ddr_ready : default_ready;

    // Transfer accepted but not finished
    assign pending = cpu_req.valid && !cpu_ready;

    assign target_sel[soc_pkg::SEL_RAM]  = pending && (region == soc_pkg::REGION_RAM);
    assign target_sel[soc_pkg::SEL_GPIO] = pending && (region == soc_pkg::REGION_GPIO);
    assign target_sel[soc_pkg::SEL_VRAM] = pending && (region == soc_pkg::REGION_VRAM);

    // DDR valid stays up for the whole stretched transfer
    assign ddr_req.valid = cpu_req.valid && (region == soc_pkg::REGION_DDR);
    assign ddr_req.addr  = cpu_req.addr[24:0];
    assign ddr_req.wdata = cpu_req.wdata;
    assign ddr_req.wstrb = cpu_req.wstrb;

    // Read data mux
    // Video RAM has no bus read path and shares the all-ones default
    always_comb begin
        case (region)
            soc_pkg::REGION_RAM:  cpu_rdata = ram_rdata;
            soc_pkg::REGION_DDR:  cpu_rdata = ddr_rdata;
            soc_pkg::REGION_GPIO: cpu_rdata = gpio_rdata;
            default:              cpu_rdata = soc_pkg::UNMAPPED_DATA;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/pano_soc.sv ====
`default_nettype none

module pano_soc #(
    parameter int MEM_WORDS = 1024
) (
    input  wire                      clk_rv,
    input  wire                      rst_rv,
    // CPU memory port
    input  wire soc_pkg::cpu_req_t   cpu_req,
    input  wire soc_pkg::word_t      la_addr,
    output logic                     cpu_ready,
    output soc_pkg::word_t           cpu_rdata,
    // DDR bridge
    output soc_pkg::ddr_req_t        ddr_req,
    input  wire                      ddr_ready,
    input  wire soc_pkg::word_t      ddr_rdata,
    // Board GPIO
    output soc_pkg::gpio_pins_t      gpio_pins,
    input  wire                      spi_miso,
    input  wire [4:0]                delay_sel_det,
    output logic [4:0]               delay_sel_val,
    // Text display cell lookup
    input  wire soc_pkg::col_t       char_col,
    input  wire soc_pkg::row_t       char_row,
    output soc_pkg::char_code_t      char_code
);

    soc_pkg::word_t ram_rdata;
    soc_pkg::word_t gpio_rdata;
    logic [2:0]     target_sel;

    // ------------------------------------------------------------------
    // Bus decode
    // ------------------------------------------------------------------

    mem_bus_decode #(
        .MEM_WORDS  (MEM_WORDS)
    ) u_decode (
        .clk_rv     (clk_rv),
        .rst_rv     (rst_rv),
        .cpu_req    (cpu_req),
        .la_addr    (la_addr),
        .ddr_ready  (ddr_ready),
        .ddr_rdata  (ddr_rdata),
        .ram_rdata  (ram_rdata),
        .gpio_rdata (gpio_rdata),
        .cpu_ready  (cpu_ready),
        .cpu_rdata  (cpu_rdata),
        .ddr_req    (ddr_req),
        .region     (),
        .target_sel (target_sel)
    );

    // ------------------------------------------------------------------
    // Targets
    // ------------------------------------------------------------------

    sram_words #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ram (
        .clk_rv    (clk_rv),
        .sel       (target_sel[soc_pkg::SEL_RAM]),
        .wstrb     (cpu_req.wstrb),
        .addr      (cpu_req.addr),
        .wdata     (cpu_req.wdata),
        .rdata     (ram_rdata)
    );

    gpio_regs u_gpio (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .sel           (target_sel[soc_pkg::SEL_GPIO]),
        .wstrb         (cpu_req.wstrb),
        .addr          (cpu_req.addr),
        .wdata         (cpu_req.wdata),
        .spi_miso      (spi_miso),
        .delay_sel_det (delay_sel_det),
        .rdata         (gpio_rdata),
        .gpio_pins     (gpio_pins),
        .delay_sel_val (delay_sel_val)
    );

    // Video memory read side shares clk_rv
    text_vram u_vram (
        .clk_rv    (clk_rv),
        .sel       (target_sel[soc_pkg::SEL_VRAM]),
        .wstrb     (cpu_req.wstrb),
        .addr      (cpu_req.addr),
        .wdata     (cpu_req.wdata),
        .char_col  (char_col),
        .char_row  (char_row),
        .char_code (char_code)
    );

endmodule

`default_nettype wire

// ==== source/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // ------------------------------------------------------------------
    // Widths with a meaning
    // ------------------------------------------------------------------

    // Bus address and data word
    typedef logic [31:0] word_t;
    // Byte write strobe where all zeros is a read
    typedef logic [3:0]  strb_t;
    // Byte address seen by the DDR bridge
    typedef logic [24:0] ddr_addr_t;
    typedef logic [6:0]  char_code_t;
    typedef logic [6:0]  col_t;
    typedef logic [4:0]  row_t;
    // Character cell index into video RAM
    typedef logic [11:0] vram_addr_t;

    // ------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------

    // Internal RAM sits at zero and its size comes from MEM_WORDS
    localparam word_t GPIO_BASE = 32'h0300_0000;
    localparam word_t GPIO_SIZE = 32'h0000_0100;
    localparam word_t VRAM_BASE = 32'h0800_0000;
    localparam word_t VRAM_SIZE = 32'h0000_4000;
    localparam word_t DDR_BASE  = 32'h0C00_0000;
    localparam word_t DDR_SIZE  = 32'h0200_0000;

    // Cells per text row
    localparam int TEXT_COLS = 80;

    // Returned for reads that hit nothing
    localparam word_t UNMAPPED_DATA = '1;

    // Bit positions inside the target select strobes
    localparam int SEL_RAM  = 0;
    localparam int SEL_GPIO = 1;
    localparam int SEL_VRAM = 2;

    // Region decoded from the look-ahead address
    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_RAM,
        REGION_VRAM,
        REGION_GPIO,
        REGION_DDR
    } region_t;

    // ------------------------------------------------------------------
    // Bus bundles
    // ------------------------------------------------------------------

    // CPU memory port request
    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t wdata;
        strb_t wstrb;
    } cpu_req_t;

    // Request toward the DDR bridge
    typedef struct packed {
        logic      valid;
        ddr_addr_t addr;
        word_t     wdata;
        strb_t     wstrb;
    } ddr_req_t;

    // Board pins driven from the GPIO block
    typedef struct packed {
        logic led_green_n;
        logic led_red_n;
        logic spi_cs_n;
        logic spi_clk;
        logic spi_mosi;
        logic usb_rst_n;
    } gpio_pins_t;

endpackage

`default_nettype wire

// ==== source/sram_words.sv ====
`default_nettype none

module sram_words #(
    parameter int MEM_WORDS = 1024
) (
    input  wire                 clk_rv,
    input  wire                 sel,
    input  wire soc_pkg::strb_t wstrb,
    input  wire soc_pkg::word_t addr,
    input  wire soc_pkg::word_t wdata,
    output soc_pkg::word_t      rdata
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    soc_pkg::word_t mem [MEM_WORDS];
    logic [IDX_W-1:0] word_idx;

    // Byte address to word index
    assign word_idx = addr[IDX_W+1:2];

    // ------------------------------------------------------------------
    // Byte-lane writes and registered read
    // ------------------------------------------------------------------

    always_ff @(posedge clk_rv) begin
        // Each strobe bit enables one byte lane
        for (int b = 0; b < 4; b++) begin
            if (sel && wstrb[b]) begin
                mem[word_idx][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // Read every cycle so data lines up with ready
    always_ff @(posedge clk_rv) begin
        rdata <= mem[word_idx];
    end

endmodule

`default_nettype wire

// ==== source/text_vram.sv ====
`default_nettype none

module text_vram (
    input  wire                 clk_rv,
    input  wire                 sel,
    input  wire soc_pkg::strb_t wstrb,
    input  wire soc_pkg::word_t addr,
    input  wire soc_pkg::word_t wdata,
    input  wire soc_pkg::col_t  char_col,
    input  wire soc_pkg::row_t  char_row,
    output soc_pkg::char_code_t char_code
);

    localparam int CELLS = 1 << $bits(soc_pkg::vram_addr_t);

    soc_pkg::char_code_t mem [CELLS];
    soc_pkg::vram_addr_t wr_cell;
    soc_pkg::vram_addr_t rd_cell;
    logic                wr_en;

    // ------------------------------------------------------------------
    // Bus write port
    // ------------------------------------------------------------------

    // One cell per bus word
    assign wr_cell = addr[13:2];
    assign wr_en   = sel && (wstrb != '0);

    // Only the low byte carries a character
    always_ff @(posedge clk_rv) begin
        if (wr_en) begin
            mem[wr_cell] <= wdata[6:0];
        end
    end

    // ------------------------------------------------------------------
    // Cell read port
    // ------------------------------------------------------------------

    // Row-major cell index
    assign rd_cell = soc_pkg::vram_addr_t'(char_row) * soc_pkg::vram_addr_t'(soc_pkg::TEXT_COLS)
                   + soc_pkg::vram_addr_t'(char_col);

    // One cycle from cell position to code
    always_ff @(posedge clk_rv) begin
        char_code <= mem[rd_cell];
    end

endmodule

`default_nettype wire

// ==== tests/bus_patterns.txt ====
# name op(W/R/C/P) addr_or_cell(row<<8|col) wdata strb expect ddr_wait
# P expect is {delay_sel_val, gpio_pins}, C expect is the character code
pins_reset      P 00000000 00000000 0 000004f8 0
ram_full        W 00000010 11223344 f 00000000 0
ram_byte1       W 00000010 aabbccdd 2 00000000 0
ram_byte3       W 00000010 55667788 8 00000000 0
ram_merge_rd    R 00000010 00000000 0 5522cc44 0
ram_clear       W 00000020 00000000 f 00000000 0
ram_low_half    W 00000020 deadbeef 3 00000000 0
ram_byte2       W 00000020 cafef00d 4 00000000 0
ram_half_rd     R 00000020 00000000 0 00febeef 0
ram_top_wr      W 00000ffc 12345678 f 00000000 0
ram_top_rd      R 00000ffc 00000000 0 12345678 0
gpio_green      W 03000004 00000001 f 00000000 0
gpio_usb        W 0300001c 00000001 f 00000000 0
gpio_delay      W 03000000 00000005 f 00000000 0
pins_after_1    P 00000000 00000000 0 00000159 0
gpio_cs_low     W 0300000c 00000000 f 00000000 0
gpio_sclk       W 03000010 00000001 f 00000000 0
pins_after_2    P 00000000 00000000 0 00000155 0
gpio_miso_rd    R 03000018 00000000 0 00000001 0
gpio_det_rd     R 03000000 00000000 0 00000013 0
gpio_wo_rd      R 03000008 00000000 0 00000000 0
vram_wr_a       W 08000294 000000c1 1 00000000 0
vram_wr_b       W 08001f3c 0000007a f 00000000 0
vram_wr_c       W 08000000 000000ff 1 00000000 0
cell_5_2        C 00000205 00000000 0 00000041 0
cell_79_24      C 0000184f 00000000 0 0000007a 0
cell_0_0        C 00000000 00000000 0 0000007f 0
vram_bus_rd     R 08000294 00000000 0 ffffffff 0
ddr_wr_w2       W 0c000010 01020304 f 00000000 2
ddr_rd_w0       R 0c000010 00000000 0 5a5a5a4a 0
ddr_rd_w5       R 0c001000 00000000 0 5a5a4a5a 5
ddr_rd_top_w3   R 0dfffffc 00000000 0 5ba5a5a6 3
ddr_wr_w1       W 0d000000 a5a5a5a5 3 00000000 1
ddr_rd_w4       R 0c000004 00000000 0 5a5a5a5e 4
unmap_ram_end   R 00001000 00000000 0 ffffffff 0
unmap_gap       R 04000000 00000000 0 ffffffff 0
unmap_gpio_end  R 03000100 00000000 0 ffffffff 0

// ==== tests/pano_soc_assert.sv ====
`default_nettype none

module pano_soc_assert (
    input wire                    clk_rv,
    input wire                    rst_rv,
    input wire soc_pkg::cpu_req_t cpu_req,
    input wire                    cpu_ready,
    input wire soc_pkg::region_t  region,
    input wire [2:0]              target_sel
);

    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------------------------------------------
    // Bus handshake rules
    // ------------------------------------------------------------------

    // Ready never without a request
    ready_needs_valid: assert property (
        @(posedge clk_rv) disable iff (!rst_rv)
        cpu_ready |-> cpu_req.valid
    ) else $error("cpu_ready seen without cpu_req.valid");

    // Local targets answer one cycle after valid rises
    local_ready_latency: assert property (
        @(posedge clk_rv) disable iff (!rst_rv)
        ($rose(cpu_req.valid) && (region != soc_pkg::REGION_DDR)) |=> cpu_ready
    ) else $error("local target ready not one cycle after valid");

    // Steering strobes are exclusive
    single_target: assert property (
        @(posedge clk_rv) disable iff (!rst_rv)
        $onehot0(target_sel)
    ) else $error("more than one target select active");

endmodule

// Attach to every decoder instance
bind mem_bus_decode pano_soc_assert u_bus_assert (
    .clk_rv     (clk_rv),
    .rst_rv     (rst_rv),
    .cpu_req    (cpu_req),
    .cpu_ready  (cpu_ready),
    .region     (region),
    .target_sel (target_sel)
);

`default_nettype wire

// ==== tests/pano_soc_checker.sv ====
`default_nettype none

module pano_soc_checker (
    input wire                       clk_rv,
    input wire                       rst_rv,
    input wire soc_pkg::cpu_req_t    cpu_req,
    input wire                       cpu_ready,
    input wire soc_pkg::word_t       cpu_rdata,
    input wire soc_pkg::ddr_req_t    ddr_req,
    input wire soc_pkg::gpio_pins_t  gpio_pins,
    input wire [4:0]                 delay_sel_val,
    input wire soc_pkg::char_code_t  char_code
);

    timeunit 1ns;
    timeprecision 1ps;

    int error_count = 0;
    int check_count = 0;

    // Pending bus expectation
    bit             bus_active = 0;
    string          bus_name;
    bit             bus_read;
    bit             bus_ddr;
    soc_pkg::word_t bus_data;
    soc_pkg::word_t bus_addr;
    soc_pkg::word_t bus_wdata;
    soc_pkg::strb_t bus_wstrb;
    int             bus_lat;
    int             bus_cycles;

    // Pending cell read
    bit                  cell_active = 0;
    bit                  cell_wait;
    string               cell_name;
    soc_pkg::char_code_t cell_data;

    // ------------------------------------------------------------------
    // Expectations handed over by the testbench
    // ------------------------------------------------------------------

    task automatic expect_bus(input string name, input bit is_read, input bit is_ddr,
                              input soc_pkg::word_t addr, input soc_pkg::word_t wdata,
                              input soc_pkg::strb_t wstrb, input soc_pkg::word_t exp,
                              input int lat);
        bus_name   = name;
        bus_read   = is_read;
        bus_ddr    = is_ddr;
        bus_addr   = addr;
        bus_wdata  = wdata;
        bus_wstrb  = wstrb;
        bus_data   = exp;
        bus_lat    = lat;
        bus_cycles = 0;
        bus_active = 1;
    endtask

    task automatic expect_cell(input string name, input soc_pkg::char_code_t exp);
        cell_name   = name;
        cell_data   = exp;
        // Result shows one clock after the position is taken
        cell_wait   = 1;
        cell_active = 1;
    endtask

    // Pins are static between transfers so they are compared at once
    task automatic check_pins(input string name, input logic [10:0] exp);
        logic [10:0] act;
        act = {delay_sel_val, gpio_pins};
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAILED %s: pins expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_word(input string name, input string what,
                                input soc_pkg::word_t exp, input soc_pkg::word_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAILED %s: %s expected %h actual %h", name, what, exp, act);
        end
    endtask

    // ------------------------------------------------------------------
    // Bus completion
    // ------------------------------------------------------------------

    always @(posedge clk_rv) begin
        if (rst_rv && bus_active && cpu_req.valid) begin
            if (!cpu_ready) begin
                bus_cycles++;
            end else begin
                compare_word(bus_name, "latency", bus_lat, bus_cycles);
                if (bus_read) begin
                    compare_word(bus_name, "rdata", bus_data, cpu_rdata);
                end
                // Forwarded request toward the bridge
                if (bus_ddr) begin
                    compare_word(bus_name, "ddr valid", 1, 32'(ddr_req.valid));
                    compare_word(bus_name, "ddr addr", {7'd0, bus_addr[24:0]},
                                 32'(ddr_req.addr));
                    compare_word(bus_name, "ddr wdata", bus_wdata, ddr_req.wdata);
                    compare_word(bus_name, "ddr wstrb", 32'(bus_wstrb), 32'(ddr_req.wstrb));
                end
                bus_active = 0;
            end
        end
    end

    // Cell lookup result
    always @(posedge clk_rv) begin
        if (cell_active) begin
            if (cell_wait) begin
                cell_wait = 0;
            end else begin
                compare_word(cell_name, "char_code", 32'(cell_data), 32'(char_code));
                cell_active = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/pano_soc_tb.sv ====
`default_nettype none

module pano_soc_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // DDR model data is the address XOR this key
    localparam soc_pkg::word_t DDR_DATA_KEY = 32'h5A5A_5A5A;
    localparam logic [4:0]     DET_VALUE    = 5'h13;

    logic                clk_rv = 1'b0;
    logic                rst_rv;
    soc_pkg::cpu_req_t   cpu_req;
    soc_pkg::word_t      la_addr;
    logic                cpu_ready;
    soc_pkg::word_t      cpu_rdata;
    soc_pkg::ddr_req_t   ddr_req;
    logic                ddr_ready;
    soc_pkg::word_t      ddr_rdata;
    soc_pkg::gpio_pins_t gpio_pins;
    logic                spi_miso;
    logic [4:0]          delay_sel_det;
    logic [4:0]          delay_sel_val;
    soc_pkg::col_t       char_col;
    soc_pkg::row_t       char_row;
    soc_pkg::char_code_t char_code;

    // Pattern table
    string          p_name[$];
    string          p_op[$];
    soc_pkg::word_t p_addr[$];
    soc_pkg::word_t p_wdata[$];
    soc_pkg::word_t p_strb[$];
    soc_pkg::word_t p_exp[$];
    int             p_wait[$];

    int cycle_count = 0;
    int cycle_limit = 0;
    int setup_errors = 0;

    always #10 clk_rv = ~clk_rv;

    // DDR model read data
    assign ddr_rdata = soc_pkg::word_t'(ddr_req.addr) ^ DDR_DATA_KEY;

    pano_soc #(
        .MEM_WORDS (1024)
    ) pano_soc_i (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .cpu_req       (cpu_req),
        .la_addr       (la_addr),
        .cpu_ready     (cpu_ready),
        .cpu_rdata     (cpu_rdata),
        .ddr_req       (ddr_req),
        .ddr_ready     (ddr_ready),
        .ddr_rdata     (ddr_rdata),
        .gpio_pins     (gpio_pins),
        .spi_miso      (spi_miso),
        .delay_sel_det (delay_sel_det),
        .delay_sel_val (delay_sel_val),
        .char_col      (char_col),
        .char_row      (char_row),
        .char_code     (char_code)
    );

    pano_soc_checker chk (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .cpu_req       (cpu_req),
        .cpu_ready     (cpu_ready),
        .cpu_rdata     (cpu_rdata),
        .ddr_req       (ddr_req),
        .gpio_pins     (gpio_pins),
        .delay_sel_val (delay_sel_val),
        .char_code     (char_code)
    );

    // ------------------------------------------------------------------
    // Hang guard
    // ------------------------------------------------------------------

    always @(posedge clk_rv) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Run hung after %0d cycles waiting for the DUT", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    // Parse tests/bus_patterns.txt, skipping comments and blank lines
    task automatic load_patterns();
        int    fd;
        int    n;
        int    max_wait;
        string line;
        string name;
        string op;
        soc_pkg::word_t a;
        soc_pkg::word_t d;
        soc_pkg::word_t s;
        soc_pkg::word_t e;
        int    w;
        max_wait = 0;
        fd = $fopen("tests/bus_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file tests/bus_patterns.txt");
            setup_errors++;
            cycle_limit = 50;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %s %h %h %h %h %d", name, op, a, d, s, e, w);
                if (n == 7) begin
                    p_name.push_back(name);
                    p_op.push_back(op);
                    p_addr.push_back(a);
                    p_wdata.push_back(d);
                    p_strb.push_back(s);
                    p_exp.push_back(e);
                    p_wait.push_back(w);
                    if (w > max_wait) begin
                        max_wait = w;
                    end
                end
            end
        end
        $fclose(fd);
        cycle_limit = p_name.size() * (max_wait + 8) + 50;
    endtask

    // ------------------------------------------------------------------
    // CPU side transfer with the DDR ready model
    // ------------------------------------------------------------------

    task automatic run_transfer(input int i);
        bit is_ddr;
        bit is_read;
        int gap;
        is_ddr  = (p_addr[i] >= 32'h0C00_0000) && (p_addr[i] < 32'h0E00_0000);
        is_read = (p_op[i] == "R");
        // Look-ahead address one cycle ahead of valid
        @(negedge clk_rv);
        la_addr = p_addr[i];
        @(negedge clk_rv);
        cpu_req.valid = 1'b1;
        cpu_req.addr  = p_addr[i];
        cpu_req.wdata = p_wdata[i];
        cpu_req.wstrb = is_read ? 4'h0 : p_strb[i][3:0];
        chk.expect_bus(p_name[i], is_read, is_ddr, p_addr[i], p_wdata[i],
                       cpu_req.wstrb, p_exp[i], is_ddr ? p_wait[i] : 1);
        if (is_ddr) begin
            repeat (p_wait[i]) @(negedge clk_rv);
            ddr_ready = 1'b1;
        end
        do begin
            @(posedge clk_rv);
        end while (!cpu_ready);
        @(negedge clk_rv);
        cpu_req   = '0;
        ddr_ready = 1'b0;
        // Random idle gap
        gap = $urandom_range(1, 3);
        repeat (gap) @(negedge clk_rv);
    endtask

    task automatic run_cell_read(input int i);
        @(negedge clk_rv);
        char_col = p_addr[i][6:0];
        char_row = p_addr[i][12:8];
        chk.expect_cell(p_name[i], p_exp[i][6:0]);
        do begin
            @(posedge clk_rv);
        end while (chk.cell_active);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        cpu_req       = '0;
        la_addr       = '0;
        ddr_ready     = 1'b0;
        spi_miso      = 1'b1;
        delay_sel_det = DET_VALUE;
        char_col      = '0;
        char_row      = '0;
        rst_rv        = 1'b0;
        void'($urandom(58));
        load_patterns();
        repeat (2) @(posedge clk_rv);
        @(negedge clk_rv);
        rst_rv = 1'b1;
        for (int i = 0; i < p_name.size(); i++) begin
            case (p_op[i])
                "W", "R": run_transfer(i);
                "C":      run_cell_read(i);
                "P": begin
                    @(negedge clk_rv);
                    chk.check_pins(p_name[i], p_exp[i][10:0]);
                end
                default: begin
                    $display("Unknown operation %s in pattern %s", p_op[i], p_name[i]);
                    setup_errors++;
                end
            endcase
        end
        repeat (2) @(negedge clk_rv);
        $display("checks %0d, errors %0d, setup errors %0d",
                 chk.check_count, chk.error_count, setup_errors);
        if (chk.error_count == 0 && setup_errors == 0 && p_name.size() > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
